// ==== rtl/cnn_params.svh ====
`ifndef CNN_PARAMS_SVH
`define CNN_PARAMS_SVH

// square input image
`define CNN_IMG_DIM 16

// filtered map loses the one-pixel border
`define CNN_MAP_DIM (`CNN_IMG_DIM - 2)

// non-overlapping 2x2 pooling
`define CNN_POOL_DIM (`CNN_MAP_DIM / 2)

`define CNN_PIX_W 8

// filter only looks at the low nibble
`define CNN_NIB_W 4

// five nibbles of 15 peak at 75
`define CNN_SUM_W 8

`define CNN_HIT_THRESH 40

// holds the full 49 pooled hits
`define CNN_CNT_W 6

`endif

// ==== rtl/cnn_pix_pkg.sv ====
`include "cnn_params.svh"

package cnn_pix_pkg;

	typedef logic [`CNN_PIX_W-1:0] pixel_t;

	typedef logic [`CNN_NIB_W-1:0] nib_t;

	typedef logic [`CNN_SUM_W-1:0] filt_t;

	// one address per image pixel
	typedef logic [$clog2(`CNN_IMG_DIM * `CNN_IMG_DIM)-1:0] img_addr_t;

	// five-tap cross around one centre
	typedef struct packed {
		nib_t up;
		nib_t left;
		nib_t ctr;
		nib_t right;
		nib_t down;
	} cross_win_t;

endpackage

// ==== rtl/cnn_stage_pkg.sv ====
`include "cnn_params.svh"

package cnn_stage_pkg;

	// one address per filtered-map entry
	typedef logic [$clog2(`CNN_MAP_DIM * `CNN_MAP_DIM)-1:0] map_addr_t;

	// filter result on its way to the map store
	typedef struct packed {
		cnn_pix_pkg::filt_t sum;
		map_addr_t addr;
	} filt_wr_t;

	// four sums of one 2x2 block
	typedef struct packed {
		cnn_pix_pkg::filt_t [3:0] sum;
		logic last;
	} pool_win_t;

	typedef struct packed {
		cnn_pix_pkg::filt_t value;
		logic last;
	} pool_smp_t;

endpackage

// ==== rtl/pixel_store.sv ====
`timescale 1ns/1ps

module pixel_store #(
	parameter type elem_t = logic,
	parameter int DEPTH = 256,
	parameter int NUM_RD = 1
) (
	input  logic clk,
	input  logic we,
	input  logic [$clog2(DEPTH)-1:0] waddr,
	input  elem_t wdata,
	input  logic [$clog2(DEPTH)-1:0] raddr [NUM_RD],
	output elem_t rdata [NUM_RD]
);

	elem_t mem [DEPTH];

	always_ff @(posedge clk) begin
		if (we) begin
			mem[waddr] <= wdata;
		end
	end

	// all read ports see the array directly
	always_comb begin
		for (int i = 0; i < NUM_RD; i++) begin
			rdata[i] = mem[raddr[i]];
		end
	end

	a_waddr_range: assert property (
		@(posedge clk) we |-> int'(waddr) < DEPTH
	) else $error("pixel_store write address %0d beyond depth %0d", waddr, DEPTH);

endmodule

// ==== rtl/scan_decode.sv ====
`timescale 1ns/1ps
`include "cnn_params.svh"

module scan_decode (
	input  logic clk,
	input  logic rst,
	input  logic start,
	output logic busy,
	output cnn_pix_pkg::img_addr_t img_raddr [5],
	input  cnn_pix_pkg::pixel_t img_rdata [5],
	output cnn_pix_pkg::cross_win_t win,
	output cnn_stage_pkg::map_addr_t win_addr,
	output logic win_valid,
	output cnn_stage_pkg::map_addr_t map_raddr [4],
	input  cnn_pix_pkg::filt_t map_rdata [4],
	output cnn_stage_pkg::pool_win_t pool_win,
	output logic pool_valid
);

	localparam int IMG = `CNN_IMG_DIM;
	localparam int MAP = `CNN_MAP_DIM;
	localparam int POOL = `CNN_POOL_DIM;
	localparam int CW = $clog2(MAP);

	typedef enum logic [1:0] {IDLE, FILTER, DRAIN, POOL_RUN} state_t;

	state_t state;
	logic [CW-1:0] row;
	logic [CW-1:0] col;
	int img_ctr;
	int map_base;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
			row <= '0;
			col <= '0;
		end else begin
			case (state)
				IDLE: begin
					row <= '0;
					col <= '0;
					if (start) begin
						state <= FILTER;
					end
				end
				FILTER: begin
					if (col == CW'(MAP - 1)) begin
						col <= '0;
						if (row == CW'(MAP - 1)) begin
							row <= '0;
							state <= DRAIN;
						end else begin
							row <= row + 1'b1;
						end
					end else begin
						col <= col + 1'b1;
					end
				end
				// two idle cycles let the filter pipe land its last writes
				DRAIN: begin
					if (col == CW'(1)) begin
						col <= '0;
						state <= POOL_RUN;
					end else begin
						col <= col + 1'b1;
					end
				end
				POOL_RUN: begin
					if (col == CW'(POOL - 1)) begin
						col <= '0;
						if (row == CW'(POOL - 1)) begin
							row <= '0;
							state <= IDLE;
						end else begin
							row <= row + 1'b1;
						end
					end else begin
						col <= col + 1'b1;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	assign busy = (state != IDLE);
	assign win_valid = (state == FILTER);
	assign pool_valid = (state == POOL_RUN);

	// map (row, col) sits at image (row+1, col+1)
	assign img_ctr = (int'(row) + 1) * IMG + int'(col) + 1;
	assign img_raddr[0] = cnn_pix_pkg::img_addr_t'(img_ctr - IMG);
	assign img_raddr[1] = cnn_pix_pkg::img_addr_t'(img_ctr - 1);
	assign img_raddr[2] = cnn_pix_pkg::img_addr_t'(img_ctr);
	assign img_raddr[3] = cnn_pix_pkg::img_addr_t'(img_ctr + 1);
	assign img_raddr[4] = cnn_pix_pkg::img_addr_t'(img_ctr + IMG);

	assign win.up = cnn_pix_pkg::nib_t'(img_rdata[0]);
	assign win.left = cnn_pix_pkg::nib_t'(img_rdata[1]);
	assign win.ctr = cnn_pix_pkg::nib_t'(img_rdata[2]);
	assign win.right = cnn_pix_pkg::nib_t'(img_rdata[3]);
	assign win.down = cnn_pix_pkg::nib_t'(img_rdata[4]);
	assign win_addr = cnn_stage_pkg::map_addr_t'(int'(row) * MAP + int'(col));

	// top-left corner of the 2x2 block
	assign map_base = 2 * int'(row) * MAP + 2 * int'(col);
	assign map_raddr[0] = cnn_stage_pkg::map_addr_t'(map_base);
	assign map_raddr[1] = cnn_stage_pkg::map_addr_t'(map_base + 1);
	assign map_raddr[2] = cnn_stage_pkg::map_addr_t'(map_base + MAP);
	assign map_raddr[3] = cnn_stage_pkg::map_addr_t'(map_base + MAP + 1);

	always_comb begin
		for (int k = 0; k < 4; k++) begin
			pool_win.sum[k] = map_rdata[k];
		end
	end
	assign pool_win.last = (row == CW'(POOL - 1)) && (col == CW'(POOL - 1));

	// pooling must never overlap the filter phase or its drain
	a_phase_order: assert property (
		@(posedge clk) disable iff (rst)
		pool_valid |-> !win_valid && !$past(win_valid) && !$past(win_valid, 2)
	) else $error("pool block issued while filter windows still in flight");

endmodule

// ==== rtl/cross_filter_exec.sv ====
`timescale 1ns/1ps
`include "cnn_params.svh"

module cross_filter_exec (
	input  logic clk,
	input  logic rst,
	input  cnn_pix_pkg::cross_win_t win,
	input  cnn_stage_pkg::map_addr_t win_addr,
	input  logic win_valid,
	output cnn_stage_pkg::filt_wr_t wr,
	output logic wr_valid
);

	localparam int MAX_SUM = 5 * (2 ** `CNN_NIB_W - 1);

	logic [`CNN_NIB_W:0] p_ul;
	logic [`CNN_NIB_W:0] p_rd;
	cnn_pix_pkg::nib_t p_ctr;
	cnn_stage_pkg::map_addr_t p_addr;
	logic p_valid;

	always_ff @(posedge clk) begin
		if (rst) begin
			p_valid <= 1'b0;
			wr_valid <= 1'b0;
		end else begin
			p_valid <= win_valid;
			wr_valid <= p_valid;
		end
	end

	// stage 1 partial sums
	always_ff @(posedge clk) begin
		p_ul <= {1'b0, win.up} + {1'b0, win.left};
		p_rd <= {1'b0, win.right} + {1'b0, win.down};
		p_ctr <= win.ctr;
		p_addr <= win_addr;
	end

	// stage 2 final sum
	always_ff @(posedge clk) begin
		wr.sum <= cnn_pix_pkg::filt_t'(p_ul) + cnn_pix_pkg::filt_t'(p_rd)
			+ cnn_pix_pkg::filt_t'(p_ctr);
		wr.addr <= p_addr;
	end

	a_sum_bound: assert property (
		@(posedge clk) disable iff (rst) wr_valid |-> int'(wr.sum) <= MAX_SUM
	) else $error("filter sum %0d above %0d", wr.sum, MAX_SUM);

endmodule

// ==== rtl/max_pool_exec.sv ====
`timescale 1ns/1ps

module max_pool_exec (
	input  logic clk,
	input  logic rst,
	input  cnn_stage_pkg::pool_win_t pool_win,
	input  logic pool_valid,
	output cnn_stage_pkg::pool_smp_t smp,
	output logic smp_valid
);

	cnn_pix_pkg::filt_t max_top;
	cnn_pix_pkg::filt_t max_bot;
	cnn_pix_pkg::filt_t max_all;

	// compare tree, top pair then bottom pair
	assign max_top = (pool_win.sum[0] > pool_win.sum[1]) ? pool_win.sum[0] : pool_win.sum[1];
	assign max_bot = (pool_win.sum[2] > pool_win.sum[3]) ? pool_win.sum[2] : pool_win.sum[3];
	assign max_all = (max_top > max_bot) ? max_top : max_bot;

	always_ff @(posedge clk) begin
		if (rst) begin
			smp_valid <= 1'b0;
		end else begin
			smp_valid <= pool_valid;
		end
	end

	always_ff @(posedge clk) begin
		smp.value <= max_all;
		smp.last <= pool_win.last;
	end

	a_is_max: assert property (
		@(posedge clk) disable iff (rst)
		smp_valid |-> smp.value >= $past(pool_win.sum[0]) && smp.value >= $past(pool_win.sum[1])
			&& smp.value >= $past(pool_win.sum[2]) && smp.value >= $past(pool_win.sum[3])
	) else $error("pooled value %0d below one of its inputs", smp.value);

endmodule

// ==== rtl/hit_result.sv ====
`timescale 1ns/1ps
`include "cnn_params.svh"

module hit_result (
	input  logic clk,
	input  logic rst,
	input  logic start,
	input  cnn_stage_pkg::pool_smp_t smp,
	input  logic smp_valid,
	output logic [`CNN_CNT_W-1:0] hit_count,
	output logic done
);

	logic run;
	logic hit;
	logic accept;

	assign hit = smp.value >= cnn_pix_pkg::filt_t'(`CNN_HIT_THRESH);
	// a start mid-run is dropped, as the scan FSM does
	assign accept = start && (!run || (smp_valid && smp.last));

	always_ff @(posedge clk) begin
		if (rst) begin
			run <= 1'b0;
			done <= 1'b0;
			hit_count <= '0;
		end else if (accept) begin
			run <= 1'b1;
			done <= 1'b0;
			hit_count <= '0;
		end else if (smp_valid) begin
			if (hit) begin
				hit_count <= hit_count + 1'b1;
			end
			if (smp.last) begin
				run <= 1'b0;
				done <= 1'b1;
			end
		end
	end

	a_count_bound: assert property (
		@(posedge clk) disable iff (rst)
		int'(hit_count) <= `CNN_POOL_DIM * `CNN_POOL_DIM
	) else $error("hit count %0d above pooled map size", hit_count);

endmodule

// ==== rtl/cnn_top.sv ====
`timescale 1ns/1ps
`include "cnn_params.svh"

module cnn_top (
	input  logic clk,
	input  logic rst,
	input  logic pix_we,
	input  cnn_pix_pkg::img_addr_t pix_addr,
	input  cnn_pix_pkg::pixel_t pix_data,
	input  logic start,
	output logic busy,
	output logic done,
	output logic [`CNN_CNT_W-1:0] hit_count
);

	cnn_pix_pkg::img_addr_t img_raddr [5];
	cnn_pix_pkg::pixel_t img_rdata [5];
	cnn_pix_pkg::cross_win_t win;
	cnn_stage_pkg::map_addr_t win_addr;
	logic win_valid;
	cnn_stage_pkg::filt_wr_t wr;
	logic wr_valid;
	cnn_stage_pkg::map_addr_t map_raddr [4];
	cnn_pix_pkg::filt_t map_rdata [4];
	cnn_stage_pkg::pool_win_t pool_win;
	logic pool_valid;
	cnn_stage_pkg::pool_smp_t smp;
	logic smp_valid;

	pixel_store #(
		.elem_t(cnn_pix_pkg::pixel_t),
		.DEPTH(`CNN_IMG_DIM * `CNN_IMG_DIM),
		.NUM_RD(5)
	) u_img_store (
		.clk(clk),
		.we(pix_we),
		.waddr(pix_addr),
		.wdata(pix_data),
		.raddr(img_raddr),
		.rdata(img_rdata)
	);

	// filtered map, written by the filter and read by pooling
	pixel_store #(
		.elem_t(cnn_pix_pkg::filt_t),
		.DEPTH(`CNN_MAP_DIM * `CNN_MAP_DIM),
		.NUM_RD(4)
	) u_map_store (
		.clk(clk),
		.we(wr_valid),
		.waddr(wr.addr),
		.wdata(wr.sum),
		.raddr(map_raddr),
		.rdata(map_rdata)
	);

	scan_decode u_scan (
		.clk(clk),
		.rst(rst),
		.start(start),
		.busy(busy),
		.img_raddr(img_raddr),
		.img_rdata(img_rdata),
		.win(win),
		.win_addr(win_addr),
		.win_valid(win_valid),
		.map_raddr(map_raddr),
		.map_rdata(map_rdata),
		.pool_win(pool_win),
		.pool_valid(pool_valid)
	);

	cross_filter_exec u_filter (
		.clk(clk),
		.rst(rst),
		.win(win),
		.win_addr(win_addr),
		.win_valid(win_valid),
		.wr(wr),
		.wr_valid(wr_valid)
	);

	max_pool_exec u_pool (
		.clk(clk),
		.rst(rst),
		.pool_win(pool_win),
		.pool_valid(pool_valid),
		.smp(smp),
		.smp_valid(smp_valid)
	);

	hit_result u_hit (
		.clk(clk),
		.rst(rst),
		.start(start),
		.smp(smp),
		.smp_valid(smp_valid),
		.hit_count(hit_count),
		.done(done)
	);

endmodule

// ==== dv/tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen (
	output logic clk,
	output logic rst
);

	localparam int HALF_PERIOD = 20;
	localparam int RST_CYCLES = 2;
	localparam int DRIVE_DLY = 5;

	initial begin
		clk = 1'b0;
		forever #HALF_PERIOD clk = ~clk;
	end

	// released off the edge like every other input
	initial begin
		rst = 1'b1;
		repeat (RST_CYCLES) @(posedge clk);
		#DRIVE_DLY;
		rst = 1'b0;
	end

endmodule

// ==== dv/tb_cnn_top.sv ====
`timescale 1ns/1ps
`include "cnn_params.svh"

module tb_cnn_top;

	localparam int IMG = `CNN_IMG_DIM;
	localparam int MAP = `CNN_MAP_DIM;
	localparam int POOL = `CNN_POOL_DIM;
	localparam int NPIX = IMG * IMG;
	localparam int DRIVE_DLY = 5;
	localparam int RUN_LIMIT = 400;
	localparam int RST_LIMIT = 20;
	localparam int BUSY_POKE_AT = 60;
	// windows, drain, blocks, then the pool and count registers
	localparam int RUN_LATENCY = MAP * MAP + 2 + POOL * POOL + 2;

	typedef logic [`CNN_CNT_W-1:0] cnt_t;

	logic clk;
	logic rst;
	logic pix_we;
	cnn_pix_pkg::img_addr_t pix_addr;
	cnn_pix_pkg::pixel_t pix_data;
	logic start;
	logic busy;
	logic done;
	cnt_t hit_count;

	cnn_pix_pkg::pixel_t img [NPIX];
	logic [31:0] lfsr;
	cnt_t exp_count;
	int value_errs;
	int timeout_errs;

	tb_clk_gen u_clk (
		.clk(clk),
		.rst(rst)
	);

	cnn_top u_dut (
		.clk(clk),
		.rst(rst),
		.pix_we(pix_we),
		.pix_addr(pix_addr),
		.pix_data(pix_data),
		.start(start),
		.busy(busy),
		.done(done),
		.hit_count(hit_count)
	);

	a_reset_state: assert property (
		@(posedge clk) rst |=> !busy && !done && hit_count == '0
	) else begin
		value_errs++;
		$display("Fail at %0t: outputs not cleared by reset", $time);
	end

	a_busy_done_excl: assert property (
		@(posedge clk) disable iff (rst) !(busy && done)
	) else begin
		value_errs++;
		$display("Fail at %0t: busy and done high together", $time);
	end

	// an accepted start clears the previous result
	a_start_clears: assert property (
		@(posedge clk) disable iff (rst) start && !busy |=> busy && !done
	) else begin
		value_errs++;
		$display("Fail at %0t: start did not raise busy and clear done", $time);
	end

	// a start seen while busy must not restart the scan
	a_fixed_latency: assert property (
		@(posedge clk) disable iff (rst) start && !busy |-> ##RUN_LATENCY $rose(done)
	) else begin
		value_errs++;
		$display("Fail at %0t: done did not rise %0d cycles after start", $time,
			RUN_LATENCY);
	end

	a_done_idle: assert property (
		@(posedge clk) disable iff (rst) $rose(done) |-> !busy
	) else begin
		value_errs++;
		$display("Fail at %0t: done rose while busy", $time);
	end

	a_hit_count: assert property (
		@(posedge clk) disable iff (rst) $rose(done) |-> hit_count == exp_count
	) else begin
		value_errs++;
		$display("Fail at %0t: hit_count %0d, expected %0d", $time,
			$sampled(hit_count), exp_count);
	end

	// galois form of x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 32'h8020_0003;
		end
		return s >> 1;
	endfunction

	function automatic cnn_pix_pkg::pixel_t rand_pixel();
		cnn_pix_pkg::pixel_t px;
		px = '0;
		for (int b = 0; b < `CNN_PIX_W; b++) begin
			lfsr = lfsr_next(lfsr);
			px = {px[`CNN_PIX_W-2:0], lfsr[0]};
		end
		return px;
	endfunction

	function automatic void random_image();
		for (int a = 0; a < NPIX; a++) begin
			img[a] = rand_pixel();
		end
	endfunction

	function automatic void fill_image(input cnn_pix_pkg::pixel_t value);
		for (int a = 0; a < NPIX; a++) begin
			img[a] = value;
		end
	endfunction

	function automatic int low_nib(input int r, input int c);
		return int'(img[r * IMG + c][`CNN_NIB_W-1:0]);
	endfunction

	function automatic int model_hits();
		int fmap [MAP][MAP];
		int best;
		int hits;
		hits = 0;
		for (int r = 1; r <= MAP; r++) begin
			for (int c = 1; c <= MAP; c++) begin
				fmap[r-1][c-1] = low_nib(r - 1, c) + low_nib(r, c - 1) + low_nib(r, c)
					+ low_nib(r, c + 1) + low_nib(r + 1, c);
			end
		end
		for (int i = 0; i < POOL; i++) begin
			for (int j = 0; j < POOL; j++) begin
				best = 0;
				for (int d = 0; d < 4; d++) begin
					if (fmap[2 * i + d / 2][2 * j + d % 2] > best) begin
						best = fmap[2 * i + d / 2][2 * j + d % 2];
					end
				end
				if (best >= `CNN_HIT_THRESH) begin
					hits++;
				end
			end
		end
		return hits;
	endfunction

	task automatic step();
		@(posedge clk);
		#DRIVE_DLY;
	endtask

	task automatic load_image();
		for (int a = 0; a < NPIX; a++) begin
			pix_we = 1'b1;
			pix_addr = cnn_pix_pkg::img_addr_t'(a);
			pix_data = img[a];
			step();
		end
		pix_we = 1'b0;
	endtask

	task automatic run_image(input int expected, input bit poke_busy);
		int cycles;
		exp_count = cnt_t'(expected);
		load_image();
		start = 1'b1;
		step();
		start = 1'b0;
		// second start lands mid filter phase
		if (poke_busy) begin
			repeat (BUSY_POKE_AT) step();
			start = 1'b1;
			step();
			start = 1'b0;
		end
		cycles = 0;
		while (!done && cycles < RUN_LIMIT) begin
			step();
			cycles++;
		end
		if (!done) begin
			timeout_errs++;
			$display("timeout: done did not rise within %0d cycles at %0t", RUN_LIMIT, $time);
		end
		step();
	endtask

	initial begin
		int cycles;
		pix_we = 1'b0;
		pix_addr = '0;
		pix_data = '0;
		start = 1'b0;
		lfsr = 32'hc55da6ab;
		exp_count = '0;
		value_errs = 0;
		timeout_errs = 0;

		cycles = 0;
		while (rst && cycles < RST_LIMIT) begin
			step();
			cycles++;
		end
		if (rst) begin
			timeout_errs++;
			$display("timeout: reset was never released");
		end
		step();

		random_image();
		run_image(model_hits(), 1'b1);

		fill_image(8'h00);
		run_image(0, 1'b0);

		// every sum is 75
		fill_image(8'h0F);
		run_image(POOL * POOL, 1'b0);

		// high nibble never reaches the filter
		fill_image(8'hF0);
		run_image(0, 1'b0);

		random_image();
		run_image(model_hits(), 1'b0);

		$display("errors: %0d value, %0d timeout", value_errs, timeout_errs);
		if (value_errs == 0 && timeout_errs == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

// ==== cnn_top.f ====
+incdir+rtl
rtl/cnn_pix_pkg.sv
rtl/cnn_stage_pkg.sv
rtl/pixel_store.sv
rtl/scan_decode.sv
rtl/cross_filter_exec.sv
rtl/max_pool_exec.sv
rtl/hit_result.sv
rtl/cnn_top.sv
dv/tb_clk_gen.sv
dv/tb_cnn_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
TB_TOP ?= tb_cnn_top
RTL_TOP ?= cnn_top
FILELIST ?= cnn_top.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
PASS_STR ?= STATUS: PASS
VFLAGS ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP)

$(BUILD_DIR)/V$(TB_TOP): $(shell grep -v '^+' $(FILELIST)) rtl/cnn_params.svh
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TB_TOP)
	-./$(BUILD_DIR)/V$(TB_TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "$(PASS_STR)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
